// File: sources.f
+incdir+src
src/afu_pkg.sv
src/sync_fifo.sv
src/command_arbiter.sv
src/credit_counter.sv
src/tag_control.sv
src/response_control.sv
src/afu_control.sv
tests/afu_control_sva.sv
tests/afu_control_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the afu_control testbench with Verilator and run it.
# Exits 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module afu_control_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vafu_control_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

// File: tests/afu_control_tb.sv
/*
 * Testbench for the command and response control block.
 * Drives commands and host responses on the falling edge, models the
 * per-kind order and the tags in flight, and checks with immediate
 * assertions. Concurrent checks come from the bound sva module.
 */

`timescale 1ns/10ps

module afu_control_tb;

	import afu_pkg::*;

	// six tests take well under a thousand cycles, random traffic included
	localparam int CYCLE_LIMIT = 4000;

	// what the response outputs must show two cycles after a drive
	typedef struct packed {
		logic       valid;
		logic       error;
		cmd_kind_t  kind;
		logic [7:0] cu_id;
		logic [3:0] code;
	} expect_t;

	logic            clock;
	logic            rstn;
	logic            enabled_in;
	cmd_line_t [3:0] command_in;
	rsp_in_t         response_in;
	issued_cmd_t     command_out;
	rsp_out_t [3:0]  response_out;
	logic            response_error;
	logic [3:0]      queue_full;

	// model
	logic [31:0]     lfsr;
	cmd_line_t       pending [$];
	logic [7:0]      in_flight;
	cmd_line_t       tag_record [8];
	int              rsp_timer [8];
	expect_t         expect_pipe [2];
	logic            responses_on;
	logic            bad_tag_pending;
	int              issued_total;
	cmd_kind_t       first_kind;
	int              errors;
	int              cycle_count = 0;

	afu_control dut (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled_in           (enabled_in),
		.restart_command_in   (command_in[CMD_RESTART]),
		.wed_command_in       (command_in[CMD_WED]),
		.write_command_in     (command_in[CMD_WRITE]),
		.read_command_in      (command_in[CMD_READ]),
		.response_in          (response_in),
		.command_out          (command_out),
		.restart_response_out (response_out[CMD_RESTART]),
		.wed_response_out     (response_out[CMD_WED]),
		.write_response_out   (response_out[CMD_WRITE]),
		.read_response_out    (response_out[CMD_READ]),
		.response_error       (response_error),
		.queue_full           (queue_full)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("run stopped after %0d cycles without finishing", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic string kind_name(input int kind);
		case (kind)
			0:       return "restart";
			1:       return "wed";
			2:       return "write";
			default: return "read";
		endcase
	endfunction

	// model count of outstanding commands of one kind
	function automatic int in_flight_of(input cmd_kind_t kind);
		int count;
		count = 0;
		for (int t = 0; t < 8; t++) begin
			if (in_flight[t] && tag_record[t].kind == kind) begin
				count++;
			end
		end
		return count;
	endfunction

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("Error: %s = %h, expected %h", name, got, want);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	//////////////////////////////
	// per-cycle monitor and driver
	//////////////////////////////

	task automatic check_responses();
		expect_t due;
		string   name;
		logic    want_valid;
		due = expect_pipe[1];
		assert (response_error == (due.valid && due.error))
			else value_mismatch("response_error", response_error, due.valid && due.error);
		for (int k = 0; k < 4; k++) begin
			name = {kind_name(k), "_response_out"};
			want_valid = due.valid && !due.error && due.kind == k;
			assert (response_out[k].valid == want_valid)
				else value_mismatch({name, ".valid"}, response_out[k].valid, want_valid);
			if (response_out[k].valid && due.valid) begin
				assert (response_out[k].cu_id == due.cu_id)
					else value_mismatch({name, ".cu_id"}, response_out[k].cu_id, due.cu_id);
				assert (response_out[k].code == due.code)
					else value_mismatch({name, ".code"}, response_out[k].code, due.code);
			end
		end
	endtask

	task automatic check_command();
		int   index;
		tag_t tag;
		if (command_out.valid) begin
			tag = command_out.tag;
			// oldest pending line of the same kind
			index = -1;
			for (int i = pending.size() - 1; i >= 0; i--) begin
				if (pending[i].kind == command_out.kind) begin
					index = i;
				end
			end
			if (index < 0) begin
				report_failure("command issued with no pending command of its kind");
			end else begin
				assert (command_out.address == pending[index].address)
					else value_mismatch("command_out.address", command_out.address,
						pending[index].address);
				assert (command_out.cu_id == pending[index].cu_id)
					else value_mismatch("command_out.cu_id", command_out.cu_id,
						pending[index].cu_id);
				pending.delete(index);
			end
			assert (!in_flight[tag])
				else report_failure($sformatf("tag %0d issued while still in flight", tag));
			in_flight[tag] = 1'b1;
			tag_record[tag].kind = command_out.kind;
			tag_record[tag].cu_id = command_out.cu_id;
			rsp_timer[tag] = random_bits(3);
			if (issued_total == 0) begin
				first_kind = command_out.kind;
			end
			issued_total++;
			assert (in_flight_of(CMD_READ) <= 4)
				else report_failure("more than 4 read commands outstanding");
			assert (in_flight_of(CMD_WRITE) <= 4)
				else report_failure("more than 4 write commands outstanding");
		end
	endtask

	task automatic drive_response();
		expect_t incoming;
		int      chosen;
		incoming = '0;
		response_in = '0;
		chosen = -1;
		for (int t = 0; t < 8; t++) begin
			if (in_flight[t] && rsp_timer[t] > 0) begin
				rsp_timer[t]--;
			end
		end
		if (bad_tag_pending) begin
			response_in.tag = tag_t'(random_bits(3));
			// only a tag that is free in the model
			if (!in_flight[response_in.tag]) begin
				response_in.valid = 1'b1;
				response_in.code = random_bits(4);
				incoming.valid = 1'b1;
				incoming.error = 1'b1;
				bad_tag_pending = 1'b0;
			end
		end else if (responses_on) begin
			for (int t = 7; t >= 0; t--) begin
				if (in_flight[t] && rsp_timer[t] == 0) begin
					chosen = t;
				end
			end
			if (chosen >= 0) begin
				response_in.valid = 1'b1;
				response_in.tag = tag_t'(chosen);
				response_in.code = random_bits(4);
				incoming.valid = 1'b1;
				incoming.kind = tag_record[chosen].kind;
				incoming.cu_id = tag_record[chosen].cu_id;
				incoming.code = response_in.code;
				in_flight[chosen] = 1'b0;
			end
		end
		expect_pipe[1] = expect_pipe[0];
		expect_pipe[0] = incoming;
	endtask

	// one falling edge: check, clear command strobes, answer the host side
	task automatic step();
		@(negedge clock);
		check_responses();
		check_command();
		command_in = '0;
		drive_response();
	endtask

	task automatic push_command(input cmd_kind_t kind);
		cmd_line_t line;
		line.valid = 1'b1;
		line.kind = kind;
		line.address = random_bits(32);
		line.cu_id = random_bits(8);
		command_in[kind] = line;
		pending.push_back(line);
	endtask

	task automatic wait_issued(input int count);
		while (issued_total < count) begin
			step();
		end
	endtask

	task automatic wait_idle();
		while (pending.size() != 0 || in_flight != '0 || expect_pipe[0].valid ||
			expect_pipe[1].valid) begin
			step();
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		$display("test %-8s %s, %0d errors", name,
			(errors == errors_before) ? "passed" : "failed", errors - errors_before);
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	initial begin
		int        mark;
		int        issued_before;
		cmd_kind_t kind;
		lfsr = 32'heb01;
		rstn = 1'b0;
		enabled_in = 1'b0;
		command_in = '0;
		response_in = '0;
		in_flight = '0;
		expect_pipe[0] = '0;
		expect_pipe[1] = '0;
		responses_on = 1'b1;
		bad_tag_pending = 1'b0;
		issued_total = 0;
		first_kind = CMD_READ;
		errors = 0;
		repeat (2) @(negedge clock);
		rstn = 1'b1;

		// reset state
		mark = errors;
		repeat (4) begin
			step();
			assert (queue_full == 4'd0) else value_mismatch("queue_full", queue_full, 0);
			assert (!command_out.valid)
				else value_mismatch("command_out.valid", command_out.valid, 0);
		end
		end_test("reset", mark);

		// restart and read loaded together while disabled, restart first
		mark = errors;
		step();
		push_command(CMD_RESTART);
		push_command(CMD_READ);
		step();
		enabled_in = 1'b1;
		wait_issued(1);
		assert (first_kind == CMD_RESTART)
			else value_mismatch("command_out.kind", first_kind, CMD_RESTART);
		for (int i = 0; i < 12; i++) begin
			step();
			push_command(cmd_kind_t'(i % 4));
		end
		wait_idle();
		end_test("priority", mark);

		// class credits with the host silent, one class at a time so tags stay free
		mark = errors;
		for (int c = 0; c < 2; c++) begin
			kind = (c == 0) ? CMD_READ : CMD_WRITE;
			responses_on = 1'b0;
			issued_before = issued_total;
			for (int i = 0; i < 6; i++) begin
				step();
				push_command(kind);
			end
			wait_issued(issued_before + 4);
			repeat (20) step();
			assert (issued_total == issued_before + 4)
				else report_failure({kind_name(kind),
					" command issued with no class credit left"});
			// the last two leave only once credits come back
			responses_on = 1'b1;
			wait_idle();
		end
		end_test("credits", mark);

		// random traffic, random response delays
		mark = errors;
		for (int i = 0; i < 200; i++) begin
			step();
			kind = cmd_kind_t'(random_bits(2));
			if (random_bits(1) && !queue_full[kind]) begin
				push_command(kind);
			end
		end
		wait_idle();
		end_test("tags", mark);

		// routing by kind, then a response with a free tag
		mark = errors;
		for (int i = 0; i < 8; i++) begin
			step();
			push_command(cmd_kind_t'(i % 4));
		end
		wait_idle();
		bad_tag_pending = 1'b1;
		step();
		wait_idle();
		end_test("routing", mark);

		// enable falls while wed commands are still leaving
		mark = errors;
		responses_on = 1'b0;
		for (int i = 0; i < 8; i++) begin
			step();
			push_command(CMD_WED);
		end
		enabled_in = 1'b0;
		// one last command may still show in the first cycle
		step();
		issued_before = issued_total;
		repeat (10) step();
		assert (issued_total == issued_before)
			else report_failure("command issued after the enable fell");
		// tags were dropped with the enable
		in_flight = '0;
		responses_on = 1'b1;
		enabled_in = 1'b1;
		wait_idle();
		end_test("enable", mark);

		$display("tests 6, errors %0d, assertion failures %0d", errors, dut.checks.failures);
		if (errors == 0 && dut.checks.failures == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: tests/afu_control_sva.sv
/*
 * Concurrent checks on the control block, bound into afu_control.
 * Covers the reset state, issue gating by tag and credit, grants
 * while disabled and the two-cycle response timing.
 */

`timescale 1ns/10ps

module afu_control_sva (
	input logic                 clock,
	input logic                 rstn,
	input logic                 enabled,
	input logic [3:0]           grant,
	input logic                 tag_ready,
	input logic                 total_available,
	input afu_pkg::rsp_in_t     response_in,
	input afu_pkg::issued_cmd_t command_out,
	input afu_pkg::rsp_out_t    restart_response_out,
	input afu_pkg::rsp_out_t    wed_response_out,
	input afu_pkg::rsp_out_t    write_response_out,
	input afu_pkg::rsp_out_t    read_response_out,
	input logic                 response_error,
	input logic [3:0]           queue_full
);

	int   failures = 0;
	logic any_response;

	assign any_response = restart_response_out.valid | wed_response_out.valid |
		write_response_out.valid | read_response_out.valid;

	// everything quiet while in reset
	reset_quiet: assert property (@(posedge clock)
		!rstn |-> !command_out.valid && !any_response && !response_error && queue_full == 4'd0)
		else begin
			failures++;
			$error("output active during reset");
		end

	// a command leaves only with a tag and a total credit
	issue_gated: assert property (@(posedge clock) disable iff (!rstn)
		command_out.valid |-> $past(enabled && tag_ready && total_available))
		else begin
			failures++;
			$error("command issued without tag, credit or enable");
		end

	no_grant_disabled: assert property (@(posedge clock) disable iff (!rstn)
		!enabled |-> grant == 4'd0)
		else begin
			failures++;
			$error("queue granted while disabled");
		end

	grant_onehot: assert property (@(posedge clock) disable iff (!rstn) $onehot0(grant))
		else begin
			failures++;
			$error("more than one queue granted");
		end

	// latch then routed register
	response_timing: assert property (@(posedge clock) disable iff (!rstn)
		(any_response || response_error) |-> $past(response_in.valid, 2))
		else begin
			failures++;
			$error("response output without a response two cycles before");
		end

	error_exclusive: assert property (@(posedge clock) disable iff (!rstn)
		response_error |-> !any_response)
		else begin
			failures++;
			$error("response routed together with an unknown tag error");
		end

endmodule

bind afu_control afu_control_sva checks (.*);

// File: src/afu_control.sv
/*
 * Command side of the host interface control block.
 * Four command queues feed a fixed-priority arbiter into the issue queue;
 * commands leave with a tag when a tag and a total credit are free.
 * Host responses are routed back by tag. enabled_in gates everything.
 */

`timescale 1ns/10ps
`include "afu_params.svh"

module afu_control (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled_in,
	input  afu_pkg::cmd_line_t   restart_command_in,
	input  afu_pkg::cmd_line_t   wed_command_in,
	input  afu_pkg::cmd_line_t   write_command_in,
	input  afu_pkg::cmd_line_t   read_command_in,
	input  afu_pkg::rsp_in_t     response_in,
	output afu_pkg::issued_cmd_t command_out,
	output afu_pkg::rsp_out_t    restart_response_out,
	output afu_pkg::rsp_out_t    wed_response_out,
	output afu_pkg::rsp_out_t    write_response_out,
	output afu_pkg::rsp_out_t    read_response_out,
	output logic                 response_error,
	output logic [3:0]           queue_full
);

	import afu_pkg::*;

	logic            enabled;

	// queue side, index follows cmd_kind_t
	cmd_line_t [3:0] command_lines;
	cmd_line_t [3:0] heads;
	logic [3:0]      queue_empty;
	logic [3:0]      requests;
	logic [3:0]      grant;
	cmd_line_t       granted_line;

	// issue side
	cmd_line_t       issue_head;
	logic            issue_empty;
	logic            issue_almost_full;
	logic            issue_pop;
	tag_t            free_tag;
	logic            tag_ready;

	// credits
	logic            total_available;
	logic            read_available;
	logic            write_available;
	logic            read_returned;
	logic            write_returned;
	logic            total_returned;

	// response lookup
	logic            lookup_valid;
	tag_t            lookup_tag;
	logic            lookup_hit;
	cmd_kind_t       lookup_kind;
	logic [7:0]      lookup_cu_id;

	//////////////////////////////
	// enable
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////
	// command queues
	//////////////////////////////

	assign command_lines[CMD_RESTART] = restart_command_in;
	assign command_lines[CMD_WED]     = wed_command_in;
	assign command_lines[CMD_WRITE]   = write_command_in;
	assign command_lines[CMD_READ]    = read_command_in;

	// filled even while disabled, drained only when enabled
	for (genvar q = 0; q < 4; q++) begin : command_queues
		sync_fifo #(
			.payload_t (cmd_line_t),
			.DEPTH     (`AFU_CMD_QUEUE_DEPTH),
			.HEADROOM  (`AFU_CMD_QUEUE_DEPTH / 2)
		) queue (
			.clock       (clock),
			.rstn        (rstn),
			.push        (command_lines[q].valid),
			.data_in     (command_lines[q]),
			.pop         (grant[q]),
			.data_out    (heads[q]),
			.empty       (queue_empty[q]),
			.full        (queue_full[q]),
			.almost_full ()
		);
	end

	//////////////////////////////
	// arbitration
	//////////////////////////////

	// hold everything while the issue queue nears full
	assign requests[CMD_RESTART] = ~queue_empty[CMD_RESTART] & ~issue_almost_full;
	assign requests[CMD_WED]     = ~queue_empty[CMD_WED] & ~issue_almost_full;
	assign requests[CMD_WRITE]   = ~queue_empty[CMD_WRITE] & ~issue_almost_full & write_available;
	assign requests[CMD_READ]    = ~queue_empty[CMD_READ] & ~issue_almost_full & read_available;

	command_arbiter arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.requests     (requests),
		.heads        (heads),
		.grant        (grant),
		.granted_line (granted_line)
	);

	//////////////////////////////
	// issue queue and register
	//////////////////////////////

	sync_fifo #(
		.payload_t (cmd_line_t),
		.DEPTH     (`AFU_ISSUE_DEPTH),
		.HEADROOM  (`AFU_ISSUE_HEADROOM)
	) issue_queue (
		.clock       (clock),
		.rstn        (rstn),
		.push        (granted_line.valid),
		.data_in     (granted_line),
		.pop         (issue_pop),
		.data_out    (issue_head),
		.empty       (issue_empty),
		.full        (),
		.almost_full (issue_almost_full)
	);

	// leaves only with a tag and a total credit
	assign issue_pop = enabled & ~issue_empty & tag_ready & total_available;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_out <= '0;
		end else begin
			command_out.valid <= issue_pop;
			if (issue_pop) begin
				command_out.kind    <= issue_head.kind;
				command_out.address <= issue_head.address;
				command_out.cu_id   <= issue_head.cu_id;
				command_out.tag     <= free_tag;
			end
		end
	end

	//////////////////////////////
	// credits
	//////////////////////////////

	credit_counter #(.LIMIT(`AFU_CREDITS_TOTAL)) total_credits (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.take      (issue_pop),
		.give_back (total_returned),
		.available (total_available)
	);

	// class credits taken at grant, not at issue
	credit_counter #(.LIMIT(`AFU_CREDITS_READ)) read_credits (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.take      (grant[CMD_READ]),
		.give_back (read_returned),
		.available (read_available)
	);

	credit_counter #(.LIMIT(`AFU_CREDITS_WRITE)) write_credits (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.take      (grant[CMD_WRITE]),
		.give_back (write_returned),
		.available (write_available)
	);

	//////////////////////////////
	// tags and responses
	//////////////////////////////

	tag_control tags (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.alloc        (issue_pop),
		.alloc_kind   (issue_head.kind),
		.alloc_cu_id  (issue_head.cu_id),
		.free_tag     (free_tag),
		.tag_ready    (tag_ready),
		.lookup_valid (lookup_valid),
		.lookup_tag   (lookup_tag),
		.lookup_hit   (lookup_hit),
		.lookup_kind  (lookup_kind),
		.lookup_cu_id (lookup_cu_id)
	);

	response_control responses (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled              (enabled),
		.response_in          (response_in),
		.lookup_valid         (lookup_valid),
		.lookup_tag           (lookup_tag),
		.lookup_hit           (lookup_hit),
		.lookup_kind          (lookup_kind),
		.lookup_cu_id         (lookup_cu_id),
		.read_returned        (read_returned),
		.write_returned       (write_returned),
		.total_returned       (total_returned),
		.restart_response_out (restart_response_out),
		.wed_response_out     (wed_response_out),
		.write_response_out   (write_response_out),
		.read_response_out    (read_response_out),
		.response_error       (response_error)
	);

endmodule

// File: src/response_control.sv
/*
 * Host response path.
 * Latches the response, looks its tag up in tag control, then
 * registers it into the output of the command's kind, or flags an error
 * for an unknown tag. Credit returns pulse in the lookup cycle.
 */

`timescale 1ns/10ps

module response_control (
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled,
	input  afu_pkg::rsp_in_t   response_in,
	output logic               lookup_valid,
	output afu_pkg::tag_t      lookup_tag,
	input  logic               lookup_hit,
	input  afu_pkg::cmd_kind_t lookup_kind,
	input  logic [7:0]         lookup_cu_id,
	output logic               read_returned,
	output logic               write_returned,
	output logic               total_returned,
	output afu_pkg::rsp_out_t  restart_response_out,
	output afu_pkg::rsp_out_t  wed_response_out,
	output afu_pkg::rsp_out_t  write_response_out,
	output afu_pkg::rsp_out_t  read_response_out,
	output logic               response_error
);

	import afu_pkg::*;

	rsp_in_t  response_latched;
	rsp_out_t routed;

	//////////////////////////////
	// stage 1, latch and lookup
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_latched <= '0;
		end else if (!enabled) begin
			// responses dropped while disabled
			response_latched.valid <= 1'b0;
		end else begin
			response_latched <= response_in;
		end
	end

	assign lookup_valid = response_latched.valid;
	assign lookup_tag   = response_latched.tag;

	// one credit back per known response
	assign total_returned = lookup_hit;
	assign read_returned  = lookup_hit & (lookup_kind == CMD_READ);
	assign write_returned = lookup_hit & (lookup_kind == CMD_WRITE);

	always_comb begin
		routed.valid = lookup_hit;
		routed.cu_id = lookup_cu_id;
		routed.code  = response_latched.code;
	end

	//////////////////////////////
	// stage 2, routed outputs
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			restart_response_out <= '0;
			wed_response_out     <= '0;
			write_response_out   <= '0;
			read_response_out    <= '0;
			response_error       <= 1'b0;
		end else begin
			// default, all quiet
			restart_response_out.valid <= 1'b0;
			wed_response_out.valid     <= 1'b0;
			write_response_out.valid   <= 1'b0;
			read_response_out.valid    <= 1'b0;
			if (enabled && lookup_hit) begin
				case (lookup_kind)
					CMD_RESTART: restart_response_out <= routed;
					CMD_WED:     wed_response_out     <= routed;
					CMD_WRITE:   write_response_out   <= routed;
					default:     read_response_out    <= routed;
				endcase
			end
			// unknown tag
			response_error <= enabled & response_latched.valid & ~lookup_hit;
		end
	end

endmodule

// File: src/tag_control.sv
/*
 * Tag pool for commands in flight.
 * Allocation takes the lowest free tag and records kind and cu_id;
 * a response lookup returns the record in the same cycle and frees it.
 */

`timescale 1ns/10ps
`include "afu_params.svh"

module tag_control (
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled,
	input  logic               alloc,
	input  afu_pkg::cmd_kind_t alloc_kind,
	input  logic [7:0]         alloc_cu_id,
	output afu_pkg::tag_t      free_tag,
	output logic               tag_ready,
	input  logic               lookup_valid,
	input  afu_pkg::tag_t      lookup_tag,
	output logic               lookup_hit,
	output afu_pkg::cmd_kind_t lookup_kind,
	output logic [7:0]         lookup_cu_id
);

	import afu_pkg::*;

	localparam int TAG_COUNT = `AFU_TAG_COUNT;

	logic [TAG_COUNT-1:0] in_flight;
	cmd_kind_t            kind_mem [TAG_COUNT];
	logic [7:0]           cu_id_mem [TAG_COUNT];

	//////////////////////////////
	// free tag search
	//////////////////////////////

	// walk down so the lowest clear bit is kept
	always_comb begin
		free_tag = '0;
		for (int i = TAG_COUNT - 1; i >= 0; i--) begin
			if (!in_flight[i]) begin
				free_tag = tag_t'(i);
			end
		end
	end

	assign tag_ready = ~&in_flight;

	//////////////////////////////
	// lookup
	//////////////////////////////

	// a free tag never hits
	assign lookup_hit   = lookup_valid & in_flight[lookup_tag];
	assign lookup_kind  = kind_mem[lookup_tag];
	assign lookup_cu_id = cu_id_mem[lookup_tag];

	//////////////////////////////
	// bitmap and records
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_flight <= '0;
		end else if (!enabled) begin
			// credits reload while disabled, so tags go too
			in_flight <= '0;
		end else begin
			// alloc and hit never name the same tag
			if (alloc) begin
				in_flight[free_tag] <= 1'b1;
			end
			if (lookup_hit) begin
				in_flight[lookup_tag] <= 1'b0;
			end
		end
	end

	// per-tag record
	always_ff @(posedge clock) begin
		if (alloc) begin
			kind_mem[free_tag]  <= alloc_kind;
			cu_id_mem[free_tag] <= alloc_cu_id;
		end
	end

endmodule

// File: src/credit_counter.sv
/*
 * Credit count between zero and LIMIT.
 * take lowers it, give_back raises it, both together hold it.
 * Reloads LIMIT while the block is disabled.
 */

`timescale 1ns/10ps

module credit_counter #(
	parameter int LIMIT = 4
) (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  logic take,
	input  logic give_back,
	output logic available
);

	localparam int CNT_W = $clog2(LIMIT + 1);

	logic [CNT_W-1:0] count;
	logic             at_zero;
	logic             at_limit;

	assign at_zero   = (count == '0);
	assign at_limit  = (count == CNT_W'(LIMIT));
	assign available = ~at_zero;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= CNT_W'(LIMIT);
		end else if (!enabled) begin
			// idle block owns every credit
			count <= CNT_W'(LIMIT);
		end else if (take && !give_back) begin
			// saturate, a take at zero is a caller bug
			if (!at_zero) begin
				count <= count - 1'b1;
			end
		end else if (give_back && !take) begin
			if (!at_limit) begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// File: src/command_arbiter.sv
/*
 * Fixed-priority pick among the four command queues.
 * Grant is a same-cycle pop pulse; the granted line is registered
 * and pushed into the issue queue on the next cycle.
 */

`timescale 1ns/10ps

module command_arbiter (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  logic [3:0]                requests,
	input  afu_pkg::cmd_line_t [3:0]  heads,
	output logic [3:0]                grant,
	output afu_pkg::cmd_line_t        granted_line
);

	import afu_pkg::*;

	cmd_line_t selected;

	// lowest set bit wins, index 0 is restart
	assign grant = enabled ? (requests & (~requests + 4'd1)) : 4'd0;

	// one-hot mux of the head lines
	always_comb begin
		selected = '0;
		for (int i = 0; i < 4; i++) begin
			if (grant[i]) begin
				selected = heads[i];
			end
		end
		selected.valid = |grant;
	end

	//////////////////////////////
	// registered grant line
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			granted_line <= '0;
		end else if (!enabled) begin
			granted_line.valid <= 1'b0;
		end else begin
			// valid drops on idle cycles
			granted_line <= selected;
		end
	end

endmodule

// File: src/sync_fifo.sv
/*
 * Show-ahead synchronous FIFO, payload chosen by a type parameter.
 * Head entry is visible on data_out while not empty; push when full
 * and pop when empty are ignored.
 */

`timescale 1ns/10ps
`include "afu_params.svh"

module sync_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = `AFU_ISSUE_DEPTH,
	parameter int  HEADROOM  = `AFU_ISSUE_HEADROOM
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     empty,
	output logic     full,
	output logic     almost_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// wrap explicitly, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push     = push & ~full;
	assign do_pop      = pop & ~empty;
	assign empty       = (count == '0);
	assign full        = (count == CNT_W'(DEPTH));
	assign almost_full = (count >= CNT_W'(DEPTH - HEADROOM));

	// show-ahead head
	assign data_out = mem[rd_ptr];

	// storage, no reset
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// both in one cycle leaves the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/afu_pkg.sv
/*
 * Types shared by the command and response side of the control block.
 * Modules import it inside their body and use scoped names in ports.
 */

`include "afu_params.svh"

package afu_pkg;

	// command class, also the queue index and arbiter priority
	typedef enum logic [1:0] {
		CMD_RESTART = 2'd0,
		CMD_WED     = 2'd1,
		CMD_WRITE   = 2'd2,
		CMD_READ    = 2'd3
	} cmd_kind_t;

	typedef logic [$clog2(`AFU_TAG_COUNT)-1:0] tag_t;

	// one command line, valid doubles as push strobe
	typedef struct packed {
		logic        valid;
		cmd_kind_t   kind;
		logic [31:0] address;
		logic [7:0]  cu_id;
	} cmd_line_t;

	// command as driven toward the host
	typedef struct packed {
		logic        valid;
		cmd_kind_t   kind;
		logic [31:0] address;
		logic [7:0]  cu_id;
		tag_t        tag;
	} issued_cmd_t;

	// host response, tag only
	typedef struct packed {
		logic       valid;
		tag_t       tag;
		logic [3:0] code;
	} rsp_in_t;

	// routed response toward a compute unit
	typedef struct packed {
		logic       valid;
		logic [7:0] cu_id;
		logic [3:0] code;
	} rsp_out_t;

endpackage

// File: src/afu_params.svh
/*
 * Sizes and credit limits of the accelerator command path.
 * Included by the package and by the modules that size queues,
 * tags and credit counters.
 */

`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// depth of each of the four command queues
`define AFU_CMD_QUEUE_DEPTH 8

// issue queue, almost full at depth - headroom
`define AFU_ISSUE_DEPTH     16
`define AFU_ISSUE_HEADROOM  8

// tags in flight toward the host
`define AFU_TAG_COUNT       8

// credit limits, total plus per class
`define AFU_CREDITS_TOTAL   12
`define AFU_CREDITS_READ    4
`define AFU_CREDITS_WRITE   4

`endif
